// File: common/execPkg.sv
`default_nettype none

package execPkg;

    localparam int dataWidth = 16;

    // immediate arithmetic and shifts
    localparam logic [4:0] opAddi = 5'b01000;
    localparam logic [4:0] opSubi = 5'b01001;
    localparam logic [4:0] opXori = 5'b01010;
    localparam logic [4:0] opAndni = 5'b01011;
    localparam logic [4:0] opRoli = 5'b10100;
    localparam logic [4:0] opSlli = 5'b10101;
    localparam logic [4:0] opRori = 5'b10110;
    localparam logic [4:0] opSrli = 5'b10111;

    // memory, register-register and compares
    localparam logic [4:0] opSt = 5'b10000;
    localparam logic [4:0] opLd = 5'b10001;
    localparam logic [4:0] opStu = 5'b10011;
    // R-type arithmetic; the shift/rotate group sits one code below
    localparam logic [4:0] opRType = 5'b11011;
    localparam logic [4:0] opRShift = 5'b11010;
    localparam logic [4:0] opSeq = 5'b11100;
    localparam logic [4:0] opSlt = 5'b11101;
    localparam logic [4:0] opSle = 5'b11110;
    localparam logic [4:0] opSco = 5'b11111;

    // branches, low two bits are the branch type
    localparam logic [4:0] opBeqz = 5'b01100;
    localparam logic [4:0] opBnez = 5'b01101;
    localparam logic [4:0] opBltz = 5'b01110;
    localparam logic [4:0] opBgez = 5'b01111;

    localparam logic [4:0] opLbi = 5'b11000;
    localparam logic [4:0] opSlbi = 5'b10010;
    localparam logic [4:0] opBtr = 5'b11001;

    // register-relative jumps
    localparam logic [4:0] opJr = 5'b00101;
    localparam logic [4:0] opJalr = 5'b00111;

    // R-type function field
    localparam logic [1:0] fnAdd = 2'b00;
    localparam logic [1:0] fnSub = 2'b01;
    localparam logic [1:0] fnXor = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;
    localparam logic [1:0] fnRol = 2'b00;
    localparam logic [1:0] fnSll = 2'b01;
    localparam logic [1:0] fnRor = 2'b10;
    localparam logic [1:0] fnSrl = 2'b11;

    localparam logic [3:0] aluAdd = 4'h0;
    localparam logic [3:0] aluXor = 4'h1;
    localparam logic [3:0] aluAndn = 4'h2;
    localparam logic [3:0] aluRol = 4'h3;
    localparam logic [3:0] aluSll = 4'h4;
    localparam logic [3:0] aluRor = 4'h5;
    localparam logic [3:0] aluSrl = 4'h6;

endpackage

`default_nettype wire

// File: execute/aluCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module aluCtrl import execPkg::*; (
    input  wire [4:0] aluOp,
    input  wire [1:0] aluF,
    output logic [3:0] op,
    output logic       invB,
    output logic       selImm,
    output logic       selSle,
    output logic       selSeq,
    output logic       selSco,
    output logic       selBtr,
    output logic       selSlbi,
    output logic       selSlt,
    output logic       selStu
);

    always_comb begin
        op = aluAdd;
        invB = 1'b0;
        selImm = 1'b0;
        selSle = 1'b0;
        selSeq = 1'b0;
        selSco = 1'b0;
        selBtr = 1'b0;
        selSlbi = 1'b0;
        selSlt = 1'b0;
        selStu = 1'b0;
        case (aluOp)
            opSubi: invB = 1'b1;
            opXori: op = aluXor;
            opAndni: op = aluAndn;
            opRoli: op = aluRol;
            opSlli: op = aluSll;
            opRori: op = aluRor;
            opSrli: op = aluSrl;
            opRType: begin
                case (aluF)
                    fnSub: invB = 1'b1;
                    fnXor: op = aluXor;
                    fnAndn: op = aluAndn;
                    default: op = aluAdd;
                endcase
            end
            opRShift: begin
                case (aluF)
                    fnRol: op = aluRol;
                    fnSll: op = aluSll;
                    fnRor: op = aluRor;
                    default: op = aluSrl;
                endcase
            end
            // compares subtract rd1 - rd2
            opSeq: begin
                invB = 1'b1;
                selSeq = 1'b1;
            end
            opSlt: begin
                invB = 1'b1;
                selSlt = 1'b1;
            end
            opSle: begin
                invB = 1'b1;
                selSle = 1'b1;
            end
            // carry out of a plain add
            opSco: selSco = 1'b1;
            opBeqz, opBnez, opBltz, opBgez: invB = 1'b1;
            opLbi: selImm = 1'b1;
            opSlbi: selSlbi = 1'b1;
            opBtr: selBtr = 1'b1;
            opStu: selStu = 1'b1;
            default: op = aluAdd;
        endcase
    end

    assert final ($isunknown({aluOp, aluF}) ||
                  $onehot0({selImm, selSle, selSeq, selSco, selBtr, selSlbi, selSlt, selStu}))
        else $error("aluCtrl: more than one special result selected");

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import execPkg::*; (
    input  wire [dataWidth-1:0] a,
    input  wire [dataWidth-1:0] b,
    input  wire [3:0]           op,
    input  wire                 invB,
    output logic [dataWidth-1:0] result,
    output logic                 zero,
    output logic                 ofl,
    output logic                 carry,
    output logic                 err
);

    logic [dataWidth-1:0]   bIn;
    logic [dataWidth:0]     sum;
    logic [3:0]             shAmt;
    logic [2*dataWidth-1:0] rolWide;
    logic [2*dataWidth-1:0] rorWide;

    // invert plus carry-in gives two's complement subtract
    assign bIn = invB ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, bIn} + {{dataWidth{1'b0}}, invB};

    assign shAmt = b[3:0];
    assign rolWide = {a, a} << shAmt;
    assign rorWide = {a, a} >> shAmt;

    always_comb begin
        err = 1'b0;
        case (op)
            aluAdd: result = sum[dataWidth-1:0];
            aluXor: result = a ^ b;
            aluAndn: result = a & ~b;
            aluRol: result = rolWide[2*dataWidth-1:dataWidth];
            aluSll: result = a << shAmt;
            aluRor: result = rorWide[dataWidth-1:0];
            aluSrl: result = a >> shAmt;
            default: begin
                result = '0;
                err = 1'b1;
            end
        endcase
    end

    assign zero = (result == '0);
    assign carry = sum[dataWidth];
    // same-sign operands with a flipped sum sign
    assign ofl = (a[dataWidth-1] == bIn[dataWidth-1]) &&
                 (sum[dataWidth-1] != a[dataWidth-1]);

    assert final ($isunknown({a, b, op, invB}) || err || !$isunknown(result))
        else $error("alu: unknown result for a defined op");

endmodule

`default_nettype wire

// File: execute/branchCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module branchCtrl (
    input  wire       branch,
    input  wire       jump,
    input  wire [1:0] branchType,
    input  wire       zero,
    input  wire       neg,
    output logic      takeBranch
);

    logic condMet;

    // rd1 compared against 0
    always_comb begin
        case (branchType)
            2'b00: condMet = zero;
            2'b01: condMet = ~zero;
            2'b10: condMet = neg;
            default: condMet = ~neg;
        endcase
    end

    assign takeBranch = jump | (branch & condMet);

endmodule

`default_nettype wire

// File: execute/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import execPkg::*; (
    input  wire [dataWidth-1:0] pcIdEx,
    input  wire [dataWidth-1:0] pc2IdEx,
    input  wire [dataWidth-1:0] rd1IdEx,
    input  wire [dataWidth-1:0] rd2IdEx,
    input  wire [dataWidth-1:0] immIdEx,
    input  wire [4:0]           aluOpIdEx,
    input  wire [1:0]           aluFIdEx,
    input  wire                 aluSrcIdEx,
    input  wire                 branchIdEx,
    input  wire                 jumpIdEx,
    output logic [dataWidth-1:0] aluResult,
    output logic [dataWidth-1:0] nextPc,
    output logic                 takeBranch,
    output logic                 err
);

    localparam int msb = dataWidth - 1;

    logic [3:0]           op;
    logic                 invB;
    logic                 selImm, selSle, selSeq, selSco, selBtr, selSlbi, selSlt, selStu;
    logic [dataWidth-1:0] bOp;
    logic [dataWidth-1:0] aluOut;
    logic                 zero, ofl, carry;
    logic                 neg;
    logic                 sltBit;
    logic [dataWidth-1:0] btrOut;
    logic [dataWidth-1:0] slbiOut;
    logic [dataWidth-1:0] stuSum;
    logic                 isRegJump;
    logic [dataWidth-1:0] targetBase;
    logic [dataWidth-1:0] target;

    // branches test rd1 against zero
    assign bOp = branchIdEx ? '0 : (aluSrcIdEx ? immIdEx : rd2IdEx);

    aluCtrl i_aluCtrl (
        .aluOp(aluOpIdEx), .aluF(aluFIdEx), .op(op), .invB(invB),
        .selImm(selImm), .selSle(selSle), .selSeq(selSeq), .selSco(selSco),
        .selBtr(selBtr), .selSlbi(selSlbi), .selSlt(selSlt), .selStu(selStu)
    );

    alu i_alu (
        .a(rd1IdEx), .b(bOp), .op(op), .invB(invB),
        .result(aluOut), .zero(zero), .ofl(ofl), .carry(carry), .err(err)
    );

    assign neg = aluOut[msb];

    branchCtrl i_branchCtrl (
        .branch(branchIdEx), .jump(jumpIdEx), .branchType(aluOpIdEx[1:0]),
        .zero(zero), .neg(neg), .takeBranch(takeBranch)
    );

    // signs differ: rd1 sign decides, else sign of rd1 - rd2
    assign sltBit = (rd1IdEx[msb] != bOp[msb]) ? rd1IdEx[msb] : neg;

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            btrOut[i] = rd1IdEx[msb-i];
        end
    end

    assign slbiOut = (rd1IdEx << 8) | immIdEx;
    assign stuSum = rd1IdEx + immIdEx;

    always_comb begin
        if (jumpIdEx)
            aluResult = pc2IdEx;
        else if (selStu)
            aluResult = stuSum;
        else if (selSle)
            aluResult = {{msb{1'b0}}, sltBit | zero};
        else if (selSeq)
            aluResult = {{msb{1'b0}}, zero};
        else if (selSco)
            aluResult = {{msb{1'b0}}, carry};
        else if (selBtr)
            aluResult = btrOut;
        else if (selSlt)
            aluResult = {{msb{1'b0}}, sltBit};
        else if (selImm)
            aluResult = immIdEx;
        else if (selSlbi)
            aluResult = slbiOut;
        else
            aluResult = aluOut;
    end

    // next pc target adder
    assign isRegJump = (aluOpIdEx == opJr) || (aluOpIdEx == opJalr);
    assign targetBase = isRegJump ? rd1IdEx : (branchIdEx ? pcIdEx : pc2IdEx);
    assign target = targetBase + immIdEx;
    assign nextPc = (branchIdEx | jumpIdEx) ? target : pc2IdEx;

    // sign-bit compare must agree with the overflow-corrected sign
    assert final ($isunknown({rd1IdEx, bOp, invB}) || !selSlt || sltBit == (neg ^ ofl))
        else $error("execute: slt sign logic disagrees with alu flags");

endmodule

`default_nettype wire

// File: execute/exMemReg.sv
`timescale 1ns/1ps
`default_nettype none

module exMemReg import execPkg::*; (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire [dataWidth-1:0] aluResult,
    input  wire [dataWidth-1:0] nextPc,
    input  wire                 takeBranch,
    input  wire [dataWidth-1:0] rd2IdEx,
    input  wire [2:0]           wrRIdEx,
    input  wire                 regWriteIdEx,
    input  wire                 memToRegIdEx,
    input  wire                 memWriteIdEx,
    input  wire                 memReadIdEx,
    input  wire                 dumpIdEx,
    input  wire                 haltIdEx,
    input  wire                 jalIdEx,
    output logic [dataWidth-1:0] aluOutExMem,
    output logic [dataWidth-1:0] pcSelExMem,
    output logic                 takeBranchExMem,
    output logic [dataWidth-1:0] rd2ExMem,
    output logic [2:0]           wrRExMem,
    output logic                 regWriteExMem,
    output logic                 memToRegExMem,
    output logic                 memWriteExMem,
    output logic                 memReadExMem,
    output logic                 dumpExMem,
    output logic                 haltExMem,
    output logic                 jalExMem
);

    logic regWriteIn;
    logic memWriteIn;
    logic memReadIn;
    logic haltIn;

    // squash the wrong-path instruction behind a taken branch
    assign regWriteIn = regWriteIdEx & (jalIdEx | ~takeBranchExMem);
    assign memWriteIn = memWriteIdEx & ~takeBranchExMem;
    assign memReadIn = memReadIdEx & ~takeBranchExMem;
    assign haltIn = haltIdEx & ~takeBranchExMem;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluOutExMem <= '0;
            pcSelExMem <= '0;
            takeBranchExMem <= 1'b0;
            rd2ExMem <= '0;
            wrRExMem <= '0;
            regWriteExMem <= 1'b0;
            memToRegExMem <= 1'b0;
            memWriteExMem <= 1'b0;
            memReadExMem <= 1'b0;
            dumpExMem <= 1'b0;
            haltExMem <= 1'b0;
            jalExMem <= 1'b0;
        end else begin
            aluOutExMem <= aluResult;
            pcSelExMem <= nextPc;
            takeBranchExMem <= takeBranch;
            rd2ExMem <= rd2IdEx;
            wrRExMem <= wrRIdEx;
            regWriteExMem <= regWriteIn;
            memToRegExMem <= memToRegIdEx;
            memWriteExMem <= memWriteIn;
            memReadExMem <= memReadIn;
            dumpExMem <= dumpIdEx;
            haltExMem <= haltIn;
            jalExMem <= jalIdEx;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !(memWriteExMem && memReadExMem))
        else $error("exMemReg: memory read and write in the same slot");

endmodule

`default_nettype wire

// File: verilog/exStageTop.sv
`timescale 1ns/1ps
`default_nettype none

module exStageTop import execPkg::*; (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire [dataWidth-1:0] pcIdEx,
    input  wire [dataWidth-1:0] pc2IdEx,
    input  wire [dataWidth-1:0] rd1IdEx,
    input  wire [dataWidth-1:0] rd2IdEx,
    input  wire [dataWidth-1:0] immIdEx,
    input  wire [4:0]           aluOpIdEx,
    input  wire [1:0]           aluFIdEx,
    input  wire                 aluSrcIdEx,
    input  wire                 branchIdEx,
    input  wire                 jumpIdEx,
    input  wire [2:0]           wrRIdEx,
    input  wire                 regWriteIdEx,
    input  wire                 memToRegIdEx,
    input  wire                 memWriteIdEx,
    input  wire                 memReadIdEx,
    input  wire                 dumpIdEx,
    input  wire                 haltIdEx,
    input  wire                 jalIdEx,
    output logic [dataWidth-1:0] aluOutExMem,
    output logic [dataWidth-1:0] pcSelExMem,
    output logic                 takeBranchExMem,
    output logic [dataWidth-1:0] rd2ExMem,
    output logic [2:0]           wrRExMem,
    output logic                 regWriteExMem,
    output logic                 memToRegExMem,
    output logic                 memWriteExMem,
    output logic                 memReadExMem,
    output logic                 dumpExMem,
    output logic                 haltExMem,
    output logic                 jalExMem,
    output logic                 err
);

    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] nextPc;
    logic                 takeBranch;

    execute i_execute (
        .pcIdEx(pcIdEx), .pc2IdEx(pc2IdEx), .rd1IdEx(rd1IdEx), .rd2IdEx(rd2IdEx),
        .immIdEx(immIdEx), .aluOpIdEx(aluOpIdEx), .aluFIdEx(aluFIdEx),
        .aluSrcIdEx(aluSrcIdEx), .branchIdEx(branchIdEx), .jumpIdEx(jumpIdEx),
        .aluResult(aluResult), .nextPc(nextPc), .takeBranch(takeBranch), .err(err)
    );

    exMemReg i_exMemReg (
        .clk(clk), .rstN(rstN), .aluResult(aluResult), .nextPc(nextPc),
        .takeBranch(takeBranch), .rd2IdEx(rd2IdEx), .wrRIdEx(wrRIdEx),
        .regWriteIdEx(regWriteIdEx), .memToRegIdEx(memToRegIdEx),
        .memWriteIdEx(memWriteIdEx), .memReadIdEx(memReadIdEx), .dumpIdEx(dumpIdEx),
        .haltIdEx(haltIdEx), .jalIdEx(jalIdEx),
        .aluOutExMem(aluOutExMem), .pcSelExMem(pcSelExMem),
        .takeBranchExMem(takeBranchExMem), .rd2ExMem(rd2ExMem), .wrRExMem(wrRExMem),
        .regWriteExMem(regWriteExMem), .memToRegExMem(memToRegExMem),
        .memWriteExMem(memWriteExMem), .memReadExMem(memReadExMem),
        .dumpExMem(dumpExMem), .haltExMem(haltExMem), .jalExMem(jalExMem)
    );

endmodule

`default_nettype wire

// File: verif/exChecker.sv
`timescale 1ns/1ps
`default_nettype none

module exChecker import execPkg::*; (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire [2:0]           phase,
    input  wire [dataWidth-1:0] pcIdEx, pc2IdEx, rd1IdEx, rd2IdEx, immIdEx,
    input  wire [4:0]           aluOpIdEx,
    input  wire [1:0]           aluFIdEx,
    input  wire                 aluSrcIdEx, branchIdEx, jumpIdEx,
    input  wire [2:0]           wrRIdEx,
    input  wire                 regWriteIdEx, memToRegIdEx, memWriteIdEx, memReadIdEx,
    input  wire                 dumpIdEx, haltIdEx, jalIdEx,
    input  wire [dataWidth-1:0] aluOutExMem, pcSelExMem, rd2ExMem,
    input  wire                 takeBranchExMem,
    input  wire [2:0]           wrRExMem,
    input  wire                 regWriteExMem, memToRegExMem, memWriteExMem, memReadExMem,
    input  wire                 dumpExMem, haltExMem, jalExMem, err,
    output int                  testsPassed,
    output int                  testsFailed,
    output logic                reportDone
);

    localparam logic [2:0] phaseDone = 3'd7;
    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] expAluOut, expPcSel, expRd2;
    logic [2:0]           expWrR;
    logic                 expTake, expRegWrite, expMemToReg, expMemWrite, expMemRead;
    logic                 expDump, expHalt, expJal;
    logic                 expValid;
    logic [2:0]           curPhase;
    int                   checks;
    int                   errors;

    initial begin
        testsPassed = 0;
        testsFailed = 0;
        reportDone = 1'b0;
        expValid = 1'b0;
        expTake = 1'b0;
        curPhase = 3'd0;
        checks = 0;
        errors = 0;
    end

    function automatic string testName(input logic [2:0] p);
        case (p)
            3'd0: return "reset";
            3'd1: return "arith";
            3'd2: return "special";
            3'd3: return "branch";
            3'd4: return "flush";
            3'd5: return "passthru";
            default: return "done";
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] rotateLeft(input logic [dataWidth-1:0] v,
                                                        input logic [3:0] n);
        return (v << n) | (v >> (dataWidth - n));
    endfunction

    function automatic logic [dataWidth-1:0] rotateRight(input logic [dataWidth-1:0] v,
                                                         input logic [3:0] n);
        return (v >> n) | (v << (dataWidth - n));
    endfunction

    function automatic logic [dataWidth-1:0] bitReverse(input logic [dataWidth-1:0] v);
        logic [dataWidth-1:0] r;
        r = '0;
        // shift in lsb first so v[0] ends up on top
        for (int i = 0; i < dataWidth; i++) begin
            r = {r[msb-1:0], v[i]};
        end
        return r;
    endfunction

    // reference result from the ISA rules
    function automatic logic [dataWidth-1:0] modelResult();
        logic [dataWidth-1:0] b;
        logic [dataWidth:0]   wide;
        b = branchIdEx ? '0 : (aluSrcIdEx ? immIdEx : rd2IdEx);
        wide = {1'b0, rd1IdEx} + {1'b0, b};
        if (jumpIdEx)
            return pc2IdEx;
        case (aluOpIdEx)
            opSubi: return rd1IdEx - b;
            opXori: return rd1IdEx ^ b;
            opAndni: return rd1IdEx & ~b;
            opRoli: return rotateLeft(rd1IdEx, b[3:0]);
            opSlli: return rd1IdEx << b[3:0];
            opRori: return rotateRight(rd1IdEx, b[3:0]);
            opSrli: return rd1IdEx >> b[3:0];
            opRType: begin
                case (aluFIdEx)
                    fnAdd: return rd1IdEx + b;
                    fnSub: return rd1IdEx - b;
                    fnXor: return rd1IdEx ^ b;
                    default: return rd1IdEx & ~b;
                endcase
            end
            opRShift: begin
                case (aluFIdEx)
                    fnRol: return rotateLeft(rd1IdEx, b[3:0]);
                    fnSll: return rd1IdEx << b[3:0];
                    fnRor: return rotateRight(rd1IdEx, b[3:0]);
                    default: return rd1IdEx >> b[3:0];
                endcase
            end
            opSeq: return {{msb{1'b0}}, rd1IdEx == b};
            opSlt: return {{msb{1'b0}}, $signed(rd1IdEx) < $signed(b)};
            opSle: return {{msb{1'b0}}, $signed(rd1IdEx) <= $signed(b)};
            opSco: return {{msb{1'b0}}, wide[dataWidth]};
            opBtr: return bitReverse(rd1IdEx);
            opSlbi: return {rd1IdEx[7:0], 8'h00} | immIdEx;
            opLbi: return immIdEx;
            opStu: return rd1IdEx + immIdEx;
            default: return wide[msb:0];
        endcase
    endfunction

    function automatic logic modelTake();
        if (jumpIdEx)
            return 1'b1;
        if (!branchIdEx)
            return 1'b0;
        case (aluOpIdEx)
            opBeqz: return rd1IdEx == '0;
            opBnez: return rd1IdEx != '0;
            opBltz: return rd1IdEx[msb];
            default: return !rd1IdEx[msb];
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] modelNextPc();
        if (jumpIdEx && (aluOpIdEx == opJr || aluOpIdEx == opJalr))
            return rd1IdEx + immIdEx;
        if (branchIdEx)
            return pcIdEx + immIdEx;
        if (jumpIdEx)
            return pc2IdEx + immIdEx;
        return pc2IdEx;
    endfunction

    task automatic compareField(input string field, input logic [dataWidth-1:0] expV,
                                input logic [dataWidth-1:0] actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("MISMATCH %s %s expected 0x%04h actual 0x%04h",
                     testName(curPhase), field, expV, actV);
        end
    endtask

    task automatic compareAll();
        compareField("aluOut", expAluOut, aluOutExMem);
        compareField("pcSel", expPcSel, pcSelExMem);
        compareField("takeBranch", expTake, takeBranchExMem);
        compareField("rd2", expRd2, rd2ExMem);
        compareField("wrR", expWrR, wrRExMem);
        compareField("regWrite", expRegWrite, regWriteExMem);
        compareField("memToReg", expMemToReg, memToRegExMem);
        compareField("memWrite", expMemWrite, memWriteExMem);
        compareField("memRead", expMemRead, memReadExMem);
        compareField("dump", expDump, dumpExMem);
        compareField("halt", expHalt, haltExMem);
        compareField("jal", expJal, jalExMem);
    endtask

    // what the register should hold after the next rising edge
    task automatic predict();
        logic flush;
        flush = expTake;
        if (!rstN) begin
            {expAluOut, expPcSel, expRd2, expWrR, expTake, expRegWrite, expMemToReg,
             expMemWrite, expMemRead, expDump, expHalt, expJal} = '0;
        end else begin
            expAluOut = modelResult();
            expPcSel = modelNextPc();
            expRd2 = rd2IdEx;
            expWrR = wrRIdEx;
            expMemToReg = memToRegIdEx;
            expDump = dumpIdEx;
            expJal = jalIdEx;
            // wrong-path slot behind a taken branch
            expRegWrite = regWriteIdEx & (jalIdEx | ~flush);
            expMemWrite = memWriteIdEx & ~flush;
            expMemRead = memReadIdEx & ~flush;
            expHalt = haltIdEx & ~flush;
            expTake = modelTake();
        end
        expValid = 1'b1;
    endtask

    task automatic finishTest();
        if (errors == 0) begin
            testsPassed++;
            $display("test %-8s %0d checks, ok", testName(curPhase), checks);
        end else begin
            testsFailed++;
            $display("test %-8s %0d checks, %0d errors", testName(curPhase), checks, errors);
        end
        checks = 0;
        errors = 0;
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!reportDone) begin
            if (expValid)
                compareAll();
            if (phase != curPhase) begin
                finishTest();
                curPhase = phase;
            end
            if (curPhase == phaseDone) begin
                reportDone = 1'b1;
            end else begin
                if (rstN)
                    compareField("err", '0, err);
                predict();
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tbExecute.sv
`timescale 1ns/1ps
`default_nettype none

module tbExecute import execPkg::*; ();

    // opcodes used only for stimulus
    localparam logic [4:0] opJ = 5'b00100;
    localparam logic [4:0] opJal = 5'b00110;
    localparam logic [4:0] opHalt = 5'b00000;

    localparam logic [2:0] phReset = 3'd0;
    localparam logic [2:0] phArith = 3'd1;
    localparam logic [2:0] phSpecial = 3'd2;
    localparam logic [2:0] phBranch = 3'd3;
    localparam logic [2:0] phFlush = 3'd4;
    localparam logic [2:0] phPass = 3'd5;
    localparam logic [2:0] phDone = 3'd7;

    localparam int clsArith = 0;
    localparam int clsSpecial = 1;
    localparam int clsBranch = 2;
    localparam int clsJump = 3;
    localparam int reportTimeout = 20;

    logic                 clk = 1'b0;
    logic                 rstN = 1'b0;
    logic [2:0]           phase = phReset;
    logic [dataWidth-1:0] pcIdEx, pc2IdEx, rd1IdEx, rd2IdEx, immIdEx;
    logic [4:0]           aluOpIdEx;
    logic [1:0]           aluFIdEx;
    logic                 aluSrcIdEx, branchIdEx, jumpIdEx;
    logic [2:0]           wrRIdEx;
    logic                 regWriteIdEx, memToRegIdEx, memWriteIdEx, memReadIdEx;
    logic                 dumpIdEx, haltIdEx, jalIdEx;
    logic [dataWidth-1:0] aluOutExMem, pcSelExMem, rd2ExMem;
    logic                 takeBranchExMem;
    logic [2:0]           wrRExMem;
    logic                 regWriteExMem, memToRegExMem, memWriteExMem, memReadExMem;
    logic                 dumpExMem, haltExMem, jalExMem, err;
    int                   testsPassed, testsFailed;
    logic                 reportDone;

    exStageTop i_dut (.*);

    exChecker i_checker (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic clearControls();
        {aluSrcIdEx, branchIdEx, jumpIdEx, regWriteIdEx, memToRegIdEx} = '0;
        {memWriteIdEx, memReadIdEx, haltIdEx, jalIdEx} = '0;
    endtask

    task automatic randomFields();
        pcIdEx = $urandom & 16'hfffe;
        pc2IdEx = pcIdEx + 16'd2;
        rd1IdEx = $urandom;
        rd2IdEx = $urandom;
        immIdEx = $urandom;
        aluFIdEx = $urandom_range(3);
        wrRIdEx = $urandom_range(7);
        dumpIdEx = $urandom_range(1);
    endtask

    task automatic makeArith();
        regWriteIdEx = 1'b1;
        if ($urandom_range(1)) begin
            // register form, function field picks the operation
            aluOpIdEx = $urandom_range(1) ? opRType : opRShift;
        end else begin
            aluSrcIdEx = 1'b1;
            case ($urandom_range(7))
                0: aluOpIdEx = opAddi;
                1: aluOpIdEx = opSubi;
                2: aluOpIdEx = opXori;
                3: aluOpIdEx = opAndni;
                4: aluOpIdEx = opRoli;
                5: aluOpIdEx = opSlli;
                6: aluOpIdEx = opRori;
                default: aluOpIdEx = opSrli;
            endcase
        end
    endtask

    task automatic makeSpecial();
        regWriteIdEx = 1'b1;
        case ($urandom_range(7))
            0: aluOpIdEx = opSeq;
            1: aluOpIdEx = opSlt;
            2: aluOpIdEx = opSle;
            3: aluOpIdEx = opSco;
            4: aluOpIdEx = opBtr;
            5: begin
                aluOpIdEx = opSlbi;
                aluSrcIdEx = 1'b1;
            end
            6: begin
                aluOpIdEx = opLbi;
                aluSrcIdEx = 1'b1;
            end
            default: begin
                aluOpIdEx = opStu;
                aluSrcIdEx = 1'b1;
                memWriteIdEx = 1'b1;
            end
        endcase
        // equal operands for seq and sle
        if ($urandom_range(3) == 0)
            rd2IdEx = rd1IdEx;
    endtask

    task automatic makeBranch();
        branchIdEx = 1'b1;
        case ($urandom_range(3))
            0: aluOpIdEx = opBeqz;
            1: aluOpIdEx = opBnez;
            2: aluOpIdEx = opBltz;
            default: aluOpIdEx = opBgez;
        endcase
        if ($urandom_range(2) == 0)
            rd1IdEx = '0;
    endtask

    task automatic makeJump();
        jumpIdEx = 1'b1;
        case ($urandom_range(3))
            0: aluOpIdEx = opJr;
            1: aluOpIdEx = opJ;
            2: aluOpIdEx = opJalr;
            default: aluOpIdEx = opJal;
        endcase
        // link forms write r7
        if (aluOpIdEx == opJalr || aluOpIdEx == opJal) begin
            jalIdEx = 1'b1;
            regWriteIdEx = 1'b1;
            wrRIdEx = 3'd7;
        end
    endtask

    task automatic makeMemOrHalt();
        aluSrcIdEx = 1'b1;
        case ($urandom_range(2))
            0: begin
                aluOpIdEx = opSt;
                memWriteIdEx = 1'b1;
            end
            1: begin
                aluOpIdEx = opLd;
                memReadIdEx = 1'b1;
                memToRegIdEx = 1'b1;
                regWriteIdEx = 1'b1;
            end
            default: begin
                aluOpIdEx = opHalt;
                aluSrcIdEx = 1'b0;
                haltIdEx = 1'b1;
            end
        endcase
    endtask

    task automatic driveClass(input int cls);
        clearControls();
        randomFields();
        case (cls)
            clsArith: makeArith();
            clsSpecial: makeSpecial();
            clsBranch: makeBranch();
            clsJump: makeJump();
            default: makeMemOrHalt();
        endcase
    endtask

    function automatic int pickClass(input logic [2:0] p);
        case (p)
            phArith: return clsArith;
            phSpecial: return clsSpecial;
            phBranch: return $urandom_range(1) ? clsBranch : clsJump;
            // taken branches mixed with the instructions they squash
            phFlush: return $urandom_range(1) ? clsBranch : $urandom_range(4, 1);
            default: return $urandom_range(4);
        endcase
    endfunction

    task automatic runPhase(input logic [2:0] p, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            phase = p;
            driveClass(pickClass(p));
        end
    endtask

    initial begin
        int waitCycles;
        void'($urandom(32'h2c442a77));
        clearControls();
        {pcIdEx, pc2IdEx, rd1IdEx, rd2IdEx, immIdEx} = '0;
        aluOpIdEx = '0;
        aluFIdEx = '0;
        wrRIdEx = '0;
        dumpIdEx = 1'b0;
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        runPhase(phArith, 150);
        runPhase(phSpecial, 150);
        runPhase(phBranch, 100);
        runPhase(phFlush, 200);
        runPhase(phPass, 200);
        @(posedge clk);
        #1;
        phase = phDone;
        clearControls();
        waitCycles = 0;
        while (!reportDone && waitCycles < reportTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (!reportDone) begin
            $display("checker did not finish its report within %0d cycles", reportTimeout);
            $display("TEST FAILED");
        end else begin
            $display("tests: %0d passed, %0d failed", testsPassed, testsFailed);
            if (testsFailed == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/execPkg.sv
execute/aluCtrl.sv
execute/alu.sv
execute/branchCtrl.sv
execute/execute.sv
execute/exMemReg.sv
verilog/exStageTop.sv
verif/exChecker.sv
verif/tbExecute.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  # package first, then leaf modules, then the top level
  - common/execPkg.sv
  - execute/aluCtrl.sv
  - execute/alu.sv
  - execute/branchCtrl.sv
  - execute/execute.sv
  - execute/exMemReg.sv
  - verilog/exStageTop.sv

  # testbench sources
  - target: test
    files:
      - verif/exChecker.sv
      - verif/tbExecute.sv
